/* src.f */
rtl/icache_pkg.sv
rtl/icache_tag_if.sv
rtl/icache_tag_array.sv
rtl/icache_way_sram.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
verif/tb_mem_model.sv
verif/tb_icache.sv

/* verif/tb_icache.sv */
`default_nettype none

module tb_icache;

	localparam int          PERIOD   = 40;
	localparam int          NUM_REQ  = 1500;
	localparam int          MAX_LAT  = 24;             // worst miss with stalls, in cycles
	localparam logic [31:0] MIX      = 32'h5a3c_96e1;
	localparam logic [31:0] TAPS     = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
	localparam logic [21:0] TAG_BASE = 22'h15a3c;

	logic clk, rst, fetch_valid, fetch_ready, flush, inst_valid, inst_ready;
	logic mem_req_valid, mem_req_ready, mem_resp_valid, running;
	icache_pkg::fetch_addr_t fetch_addr, mem_req_addr;
	icache_pkg::inst_t       inst_data;
	icache_pkg::line_t       mem_resp_data;
	logic [1:0]              req_delay;
	logic [2:0]              resp_delay;
	logic [31:0]             lfsr;

	// reference state
	icache_pkg::fetch_addr_t      q [$];  // accepted, not yet delivered
	logic [icache_pkg::TAG_W-1:0] mtag [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
	logic [icache_pkg::NUM_SETS-1:0] mvalid [icache_pkg::NUM_WAYS];
	icache_pkg::way_t        victim;
	icache_pkg::fetch_addr_t look_addr, refill_addr;
	logic look_valid, slot_full, refill_active, refill_sent, refill_drop;
	int   accepted, misses;

	icache_top icache_top_i (.clk(clk), .rst(rst), .fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready), .fetch_addr(fetch_addr), .flush(flush),
		.inst_valid(inst_valid), .inst_ready(inst_ready), .inst_data(inst_data),
		.mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_req_addr(mem_req_addr), .mem_resp_valid(mem_resp_valid),
		.mem_resp_data(mem_resp_data));

	tb_mem_model #(.MIX(MIX)) mem_i (.clk(clk), .rst(rst), .mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready), .mem_req_addr(mem_req_addr),
		.mem_resp_valid(mem_resp_valid), .mem_resp_data(mem_resp_data),
		.req_delay(req_delay), .resp_delay(resp_delay));

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ TAPS) : (lfsr >> 1);  // one step per bit
		end
		return v;
	endfunction

	function automatic icache_pkg::fetch_addr_t random_addr();
		icache_pkg::fetch_addr_t a;
		a.fields.tag      = TAG_BASE + 22'(rand_bits(3));  // eight tags
		a.fields.index    = 6'(rand_bits(2) * 21);         // four sets
		a.fields.word     = 2'(rand_bits(2));
		a.fields.byte_sel = 2'b00;
		return a;
	endfunction

	function automatic icache_pkg::inst_t expect_word(input icache_pkg::fetch_addr_t a);
		logic [31:0] b;
		b = {a.raw[31:2], 2'b00};
		return {b[15:0], b[31:16]} ^ MIX;
	endfunction

	function automatic icache_pkg::way_t predict_way(input icache_pkg::fetch_addr_t a);
		icache_pkg::way_t w;
		for (int i = 0; i < icache_pkg::NUM_WAYS; i++) begin
			w[i] = mvalid[i][a.fields.index] && (mtag[i][a.fields.index] == a.fields.tag);
		end
		return w;
	endfunction

	task automatic report_error(input string msg);
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_inst(input icache_pkg::inst_t got, want, input string what);
		if (got !== want) begin
			report_error($sformatf("%s is %h, expected %h", what, got, want));
		end
	endtask

	task automatic check_addr(input icache_pkg::fetch_addr_t got, want, input string what);
		if (got.raw !== want.raw) begin
			report_error($sformatf("%s is %h, expected %h", what, got.raw, want.raw));
		end
	endtask

	task automatic check_way(input icache_pkg::way_t got, want, input string what);
		if (got !== want) begin
			report_error($sformatf("%s is %b, expected %b", what, got, want));
		end
	endtask

	task automatic check_flag(input logic got, want, input string what);
		if (got !== want) begin
			report_error($sformatf("%s is %b, expected %b", what, got, want));
		end
	endtask

	// checks outputs seen mid-cycle, then advances the reference by one edge
	task automatic step_model();
		icache_pkg::way_t        exp_way;
		icache_pkg::fetch_addr_t line_addr;
		logic slot_free, deliver, look_go, fill;
		slot_free = !slot_full || inst_ready;
		exp_way   = look_valid ? predict_way(look_addr) : '0;
		line_addr.raw = {refill_addr.raw[31:4], 4'h0};
		check_flag(inst_valid, slot_full, "inst_valid");
		if (slot_full) check_inst(inst_data, expect_word(q[0]), "inst_data");
		check_flag(fetch_ready, !flush && !refill_active && slot_free &&
			!(look_valid && exp_way == '0), "fetch_ready");
		check_flag(mem_req_valid, refill_active && !refill_sent, "mem_req_valid");
		if (mem_req_valid) check_addr(mem_req_addr, line_addr, "mem_req_addr");
		if (look_valid && !refill_active) begin
			check_way(icache_top_i.tag_if.hit_way, exp_way, "hit way");
		end
		deliver = slot_full && inst_ready;
		look_go = look_valid && !refill_active && slot_free && !flush;
		fill    = refill_active && refill_sent && mem_resp_valid;
		if (deliver) begin
			void'(q.pop_front());
			slot_full = 1'b0;
		end
		if (look_go && exp_way != '0) begin
			slot_full  = 1'b1;
			look_valid = 1'b0;
		end else if (look_go) begin
			refill_active = 1'b1;
			refill_sent   = 1'b0;
			refill_drop   = 1'b0;
			refill_addr   = look_addr;
			misses++;
		end
		if (fill) begin
			for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
				if (victim[w]) begin
					mtag[w][refill_addr.fields.index]   = refill_addr.fields.tag;
					mvalid[w][refill_addr.fields.index] = 1'b1;
				end
			end
			victim        = {victim[2:0], victim[3]};  // next way in rotation
			refill_active = 1'b0;
			slot_full     = !refill_drop;
			look_valid    = 1'b0;
		end
		if (fetch_valid && fetch_ready) begin
			q.push_back(fetch_addr);
			look_valid = 1'b1;
			look_addr  = fetch_addr;
			accepted++;
		end
		if (mem_req_valid && mem_req_ready) refill_sent = 1'b1;
		if (flush) begin
			q.delete();
			slot_full   = 1'b0;
			look_valid  = 1'b0;
			refill_drop = refill_active;  // line still installs, no delivery
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		#1;
		req_delay  = 2'(rand_bits(2));
		resp_delay = 3'(rand_bits(3));
		if (running) begin
			fetch_valid = rand_bits(2) != 0;
			fetch_addr  = random_addr();
			inst_ready  = rand_bits(2) != 0;
			flush       = rand_bits(5) == 0;
		end else begin
			fetch_valid = 1'b0;
			inst_ready  = 1'b1;
			flush       = 1'b0;
		end
	end

	always @(negedge clk) begin
		if (!rst) step_model();
	end

	initial begin
		lfsr = 32'd86381;
		{rst, running} = 2'b10;
		{fetch_valid, flush, inst_ready} = 3'b000;
		fetch_addr = '0;
		{req_delay, resp_delay} = '0;
		{look_valid, slot_full, refill_active, refill_sent, refill_drop} = '0;
		{look_addr, refill_addr} = '0;
		victim   = 4'b0001;
		accepted = 0;
		misses   = 0;
		for (int w = 0; w < icache_pkg::NUM_WAYS; w++) mvalid[w] = '0;
		repeat (4) @(posedge clk);
		running = 1'b1;
		#1;
		rst = 1'b0;
		while (accepted < NUM_REQ) @(posedge clk);
		running = 1'b0;
		while (q.size() != 0 || refill_active) @(posedge clk);
		repeat (2) @(posedge clk);
		$display("%0d requests accepted, %0d refills", accepted, misses);
		$display("NO ERRORS");
		$finish;
	end

	initial begin
		#((4 + NUM_REQ * MAX_LAT) * PERIOD);
		$display("timeout: the cache stopped delivering before all requests were done");
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

/* verif/tb_mem_model.sv */
`default_nettype none

module tb_mem_model #(
	parameter logic [31:0] MIX = 32'h0
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    mem_req_valid,
	output logic                    mem_req_ready,
	input  icache_pkg::fetch_addr_t mem_req_addr,
	output logic                    mem_resp_valid,
	output icache_pkg::line_t       mem_resp_data,
	input  logic [1:0]              req_delay,   // cycles before ready
	input  logic [2:0]              resp_delay   // cycles from transfer to data
);

	icache_pkg::fetch_addr_t line_addr;
	int                      delay;

	// word at byte address a is a with its halves swapped, xor MIX
	function automatic icache_pkg::line_t line_data(input logic [31:0] base);
		icache_pkg::line_t line;
		logic [31:0]       a;
		for (int w = 0; w < 4; w++) begin
			a = base + 32'(4 * w);
			line[w*32 +: 32] = {a[15:0], a[31:16]} ^ MIX;
		end
		return line;
	endfunction

	initial begin
		mem_req_ready  = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data  = '0;
		forever begin
			@(posedge clk);
			if (!rst && mem_req_valid) begin
				delay = req_delay;
				repeat (delay) @(posedge clk);
				#1;
				mem_req_ready = 1'b1;
				@(posedge clk);  // request transfers here
				line_addr = mem_req_addr;
				delay     = resp_delay;
				#1;
				mem_req_ready = 1'b0;
				if (delay > 0) begin
					repeat (delay) @(posedge clk);
					#1;
				end
				mem_resp_data  = line_data(line_addr.raw);
				mem_resp_valid = 1'b1;
				@(posedge clk);  // cache takes the line
				#1;
				mem_resp_valid = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
`default_nettype none

module icache_top (
	input  logic                    clk,
	input  logic                    rst,

	input  logic                    fetch_valid,
	output logic                    fetch_ready,
	input  icache_pkg::fetch_addr_t fetch_addr,
	input  logic                    flush,

	output logic                    inst_valid,
	input  logic                    inst_ready,
	output icache_pkg::inst_t       inst_data,

	output logic                    mem_req_valid,
	input  logic                    mem_req_ready,
	output icache_pkg::fetch_addr_t mem_req_addr,
	input  logic                    mem_resp_valid,
	input  icache_pkg::line_t       mem_resp_data
);

	icache_pkg::way_t               sram_ce;
	logic                           sram_we;
	logic [icache_pkg::INDEX_W-1:0] sram_addr;
	icache_pkg::line_t              sram_wdata;
	icache_pkg::line_t              sram_rdata [icache_pkg::NUM_WAYS];

	icache_tag_if tag_if ();

	icache_tag_array tag_array_i (
		.clk (clk),
		.rst (rst),
		.tag (tag_if.array)
	);

	// one data sram per way
	for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
		icache_way_sram way_sram_i (
			.clk   (clk),
			.ce    (sram_ce[w]),
			.we    (sram_we),
			.addr  (sram_addr),
			.wdata (sram_wdata),
			.rdata (sram_rdata[w])
		);
	end

	icache_ctrl ctrl_i (
		.clk            (clk),
		.rst            (rst),
		.fetch_valid    (fetch_valid),
		.fetch_ready    (fetch_ready),
		.fetch_addr     (fetch_addr),
		.flush          (flush),
		.inst_valid     (inst_valid),
		.inst_ready     (inst_ready),
		.inst_data      (inst_data),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_addr   (mem_req_addr),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_data  (mem_resp_data),
		.tag            (tag_if.ctrl),
		.sram_ce        (sram_ce),
		.sram_we        (sram_we),
		.sram_addr      (sram_addr),
		.sram_wdata     (sram_wdata),
		.sram_rdata     (sram_rdata)
	);

endmodule

`default_nettype wire

/* rtl/icache_ctrl.sv */
`default_nettype none

module icache_ctrl (
	input  logic                           clk,
	input  logic                           rst,

	input  logic                           fetch_valid,
	output logic                           fetch_ready,
	input  icache_pkg::fetch_addr_t        fetch_addr,
	input  logic                           flush,

	output logic                           inst_valid,
	input  logic                           inst_ready,
	output icache_pkg::inst_t              inst_data,

	output logic                           mem_req_valid,
	input  logic                           mem_req_ready,
	output icache_pkg::fetch_addr_t        mem_req_addr,
	input  logic                           mem_resp_valid,
	input  icache_pkg::line_t              mem_resp_data,

	icache_tag_if.ctrl                     tag,

	output icache_pkg::way_t               sram_ce,
	output logic                           sram_we,
	output logic [icache_pkg::INDEX_W-1:0] sram_addr,
	output icache_pkg::line_t              sram_wdata,
	input  icache_pkg::line_t              sram_rdata [icache_pkg::NUM_WAYS]
);

	// lookup stage
	logic                    req_valid;   // cleared by flush, also marks a dropped refill
	icache_pkg::fetch_addr_t req_addr;
	logic                    req_hit;

	// output slot
	icache_pkg::way_t        slot_way;    // zero selects the refill line buffer
	logic [1:0]              slot_word;
	icache_pkg::line_t       slot_line;
	icache_pkg::line_t       line_buf;

	logic [1:0]              state;
	icache_pkg::way_t        victim;

	logic                    slot_free;
	logic                    lookup_ok;
	logic                    hit_go;
	logic                    miss_go;
	logic                    accept;
	logic                    fill;
	logic                    deliver;

	assign req_hit   = |tag.hit_way;
	assign slot_free = !inst_valid || inst_ready;
	assign lookup_ok = req_valid && (state == icache_pkg::ST_IDLE) && slot_free && !flush;
	assign hit_go    = lookup_ok && req_hit;
	assign miss_go   = lookup_ok && !req_hit;
	assign fill      = (state == icache_pkg::ST_WAIT) && mem_resp_valid;
	assign deliver   = fill && req_valid;  // refill not discarded by flush

	// lookup stage must empty this edge for a new request to enter
	assign fetch_ready = !flush && (state == icache_pkg::ST_IDLE) && slot_free &&
		(!req_valid || req_hit);
	assign accept = fetch_valid && fetch_ready;

	assign tag.lookup_index = req_addr.fields.index;
	assign tag.lookup_tag   = req_addr.fields.tag;
	assign tag.fill_en      = fill;
	assign tag.fill_way     = victim;
	assign tag.fill_addr    = req_addr;

	assign mem_req_valid = (state == icache_pkg::ST_REQ);
	assign mem_req_addr.raw = {req_addr.raw[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
		{icache_pkg::OFFSET_W{1'b0}}};  // line aligned

	// one sram op per edge, hit read or refill write
	assign sram_ce    = fill ? victim : (hit_go ? tag.hit_way : '0);
	assign sram_we    = fill;
	assign sram_addr  = req_addr.fields.index;
	assign sram_wdata = mem_resp_data;

	always_comb begin
		slot_line = line_buf;
		for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
			if (slot_way[w]) begin
				slot_line = sram_rdata[w];
			end
		end
	end

	assign inst_data = slot_line[slot_word * icache_pkg::INST_W +: icache_pkg::INST_W];

	always_ff @(posedge clk) begin
		if (rst) begin
			req_valid  <= 1'b0;
			inst_valid <= 1'b0;
			state      <= icache_pkg::ST_IDLE;
			victim     <= 4'b0001;
		end else begin
			if (flush) begin
				req_valid <= 1'b0;
			end else if (accept) begin
				req_valid <= 1'b1;
			end else if (hit_go || fill) begin
				req_valid <= 1'b0;
			end

			if (flush) begin
				inst_valid <= 1'b0;
			end else if (hit_go || deliver) begin
				inst_valid <= 1'b1;
			end else if (inst_ready) begin
				inst_valid <= 1'b0;
			end

			case (state)
				icache_pkg::ST_IDLE: begin
					if (miss_go) begin
						state <= icache_pkg::ST_REQ;
					end
				end
				icache_pkg::ST_REQ: begin
					if (mem_req_ready) begin
						state <= icache_pkg::ST_WAIT;
					end
				end
				icache_pkg::ST_WAIT: begin
					if (mem_resp_valid) begin
						state  <= icache_pkg::ST_IDLE;
						victim <= {victim[2:0], victim[3]};  // rotate on every refill
					end
				end
				default: begin
					state <= icache_pkg::ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= fetch_addr;
		end
		if (hit_go) begin
			slot_way  <= tag.hit_way;
			slot_word <= req_addr.fields.word;
		end else if (deliver) begin
			slot_way  <= '0;
			slot_word <= req_addr.fields.word;
		end
		if (fill) begin
			line_buf <= mem_resp_data;
		end
	end

endmodule

`default_nettype wire

/* rtl/icache_way_sram.sv */
`default_nettype none

module icache_way_sram (
	input  logic                           clk,
	input  logic                           ce,     // active high
	input  logic                           we,     // write when ce, else read
	input  logic [icache_pkg::INDEX_W-1:0] addr,
	input  icache_pkg::line_t              wdata,
	output icache_pkg::line_t              rdata
);

	icache_pkg::line_t mem [icache_pkg::NUM_SETS];

	always_ff @(posedge clk) begin
		if (ce) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];  // holds while not enabled
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/icache_tag_array.sv */
`default_nettype none

module icache_tag_array (
	input logic         clk,
	input logic         rst,
	icache_tag_if.array tag
);

	logic [icache_pkg::TAG_W-1:0]    tags  [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
	logic [icache_pkg::NUM_SETS-1:0] valid [icache_pkg::NUM_WAYS];

	logic [icache_pkg::INDEX_W-1:0]  fill_index;
	logic [icache_pkg::TAG_W-1:0]    fill_tag;

	assign fill_index = tag.fill_addr.fields.index;
	assign fill_tag   = tag.fill_addr.fields.tag;

	// hit detection, same cycle as the lookup
	always_comb begin
		for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
			tag.hit_way[w] = valid[w][tag.lookup_index] &&
				(tags[w][tag.lookup_index] == tag.lookup_tag);
		end
	end

	// tag storage, written on refill
	always_ff @(posedge clk) begin
		if (tag.fill_en) begin
			for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
				if (tag.fill_way[w]) begin
					tags[w][fill_index] <= fill_tag;
				end
			end
		end
	end

	// valid bits, only set by a fill
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if (tag.fill_en) begin
			for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
				if (tag.fill_way[w]) begin
					valid[w][fill_index] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/icache_tag_if.sv */
`default_nettype none

interface icache_tag_if;

	logic [icache_pkg::INDEX_W-1:0] lookup_index;
	logic [icache_pkg::TAG_W-1:0]   lookup_tag;
	icache_pkg::way_t               hit_way;      // combinational compare result

	logic                           fill_en;
	icache_pkg::way_t               fill_way;
	icache_pkg::fetch_addr_t        fill_addr;    // tag and index of installed line

	modport ctrl (
		output lookup_index,
		output lookup_tag,
		input  hit_way,
		output fill_en,
		output fill_way,
		output fill_addr
	);

	modport array (
		input  lookup_index,
		input  lookup_tag,
		output hit_way,
		input  fill_en,
		input  fill_way,
		input  fill_addr
	);

endinterface

`default_nettype wire

/* rtl/icache_pkg.sv */
`default_nettype none

package icache_pkg;

	// cache geometry
	localparam int ADDR_W   = 32;
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 64;
	localparam int INDEX_W  = 6;
	localparam int OFFSET_W = 4;    // 16-byte lines
	localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
	localparam int LINE_W   = 128;
	localparam int INST_W   = 32;

	// refill fsm encoding
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ  = 2'd1;  // memory request pending
	localparam logic [1:0] ST_WAIT = 2'd2;  // waiting for line data

	typedef logic [NUM_WAYS-1:0] way_t;    // one-hot
	typedef logic [LINE_W-1:0]   line_t;
	typedef logic [INST_W-1:0]   inst_t;

	// fetch address, used whole or split into cache fields
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		struct packed {
			logic [TAG_W-1:0]   tag;
			logic [INDEX_W-1:0] index;
			logic [1:0]         word;      // instruction within the line
			logic [1:0]         byte_sel;  // always zero for aligned fetch
		} fields;
	} fetch_addr_t;

endpackage

`default_nettype wire
